/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_uart_axil
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* axil_pkg.sv */
package axil_pkg;

	// bus data word width
	localparam int AXIL_DATA_W = 32;

	// write and read response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

endpackage : axil_pkg

/* fifo_if.sv */
interface fifo_if #(
	parameter int DEPTH_LOG2 = 2
);

	logic                  push;
	logic [7:0]            push_data;
	logic                  pop;
	logic [7:0]            pop_data;	// head entry
	logic                  full;
	logic                  empty;
	logic [DEPTH_LOG2:0]   count;

	modport user (
		output push, push_data, pop,
		input  pop_data, full, empty, count
	);

	modport store (
		input  push, push_data, pop,
		output pop_data, full, empty, count
	);

endinterface : fifo_if

/* sync_fifo.sv */
module sync_fifo (
	input logic    clk,
	input logic    rst,
	fifo_if.store  fifo_i
);

	// depth follows the interface count width
	localparam int DEPTH_LOG2 = $bits(fifo_i.count) - 1;
	localparam int DEPTH      = 1 << DEPTH_LOG2;

	logic [7:0]            mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   fill;

	always_ff @(posedge clk) begin
		if (fifo_i.push)
			mem[wr_ptr] <= fifo_i.push_data;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (fifo_i.push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (fifo_i.pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({fifo_i.push, fifo_i.pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	assign fifo_i.pop_data = mem[rd_ptr];
	assign fifo_i.count    = fill;
	assign fifo_i.full     = fill[DEPTH_LOG2];	// only set at exactly DEPTH
	assign fifo_i.empty    = (fill == '0);

	// the user side must respect the status flags
	push_not_full: assert property (@(posedge clk) disable iff (rst)
		fifo_i.push |-> !fifo_i.full);

	pop_not_empty: assert property (@(posedge clk) disable iff (rst)
		fifo_i.pop |-> !fifo_i.empty);

endmodule : sync_fifo

/* tb_uart_axil.sv */
module tb_uart_axil;

	localparam int TX_DEPTH     = 8;
	localparam int RX_DEPTH     = 4;
	localparam int CLKS_PER_BIT = 8;	// 800 / 100
	localparam int HS_TIMEOUT   = 200;

	// register offsets and response codes as seen from the bus
	localparam logic [3:0] OFF_DATA     = 4'h0;
	localparam logic [3:0] OFF_RX_COUNT = 4'h4;
	localparam logic [3:0] OFF_STATUS   = 4'h8;
	localparam logic [1:0] RESP_OKAY    = 2'b00;
	localparam logic [1:0] RESP_SLVERR  = 2'b10;

	logic        clk;
	logic        rst;
	logic        awvalid_i;
	logic [3:0]  awaddr_i;
	logic        wvalid_i;
	logic [31:0] wdata_i;
	logic [3:0]  wstrb_i;
	logic        bready_i;
	logic        arvalid_i;
	logic [3:0]  araddr_i;
	logic        rready_i;
	logic        awready_o;
	logic        wready_o;
	logic        bvalid_o;
	logic [1:0]  bresp_o;
	logic        arready_o;
	logic        rvalid_o;
	logic [31:0] rdata_o;
	logic [1:0]  rresp_o;
	logic        uart_rx_i;
	logic        uart_cts_i;
	logic        uart_tx_o;
	logic        uart_rts_o;

	logic [7:0] tx_exp[$];	// bytes expected on uart_tx_o
	logic [7:0] rx_exp[$];	// model of the rx fifo
	logic [7:0] mon_q[$];	// bytes decoded from uart_tx_o

	int    errors;
	int    errors_at_start;
	int    tests_passed;
	int    tests_failed;
	string test_name;

	uart_axil #(
		.CLK_FREQ      (800),
		.UART_BPS      (100),
		.TX_DEPTH_LOG2 (3),
		.RX_DEPTH_LOG2 (2)
	) uart_axil_inst (
		.clk        (clk),
		.rst        (rst),
		.awvalid_i  (awvalid_i),
		.awaddr_i   (awaddr_i),
		.wvalid_i   (wvalid_i),
		.wdata_i    (wdata_i),
		.wstrb_i    (wstrb_i),
		.bready_i   (bready_i),
		.arvalid_i  (arvalid_i),
		.araddr_i   (araddr_i),
		.rready_i   (rready_i),
		.awready_o  (awready_o),
		.wready_o   (wready_o),
		.bvalid_o   (bvalid_o),
		.bresp_o    (bresp_o),
		.arready_o  (arready_o),
		.rvalid_o   (rvalid_o),
		.rdata_o    (rdata_o),
		.rresp_o    (rresp_o),
		.uart_rx_i  (uart_rx_i),
		.uart_cts_i (uart_cts_i),
		.uart_tx_o  (uart_tx_o),
		.uart_rts_o (uart_rts_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_timeout(input string what);
		$display("ERROR: timed out waiting for %s in test %s", what, test_name);
		errors++;
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	function automatic logic [31:0] status_word(input logic tx_full, input logic rx_empty,
			input logic tx_busy);
		return {29'h0, tx_busy, rx_empty, tx_full};
	endfunction

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int delay;
		n = 0;
		delay = $urandom_range(2, 0);
		@(negedge clk);
		awvalid_i = 1'b1;
		awaddr_i  = addr;
		wvalid_i  = 1'b1;
		wdata_i   = data;
		wstrb_i   = 4'hf;
		#1;
		while (!(awready_o && wready_o)) begin
			if (n == HS_TIMEOUT) begin
				report_timeout("awready and wready");
				break;
			end
			@(negedge clk);
			#1;
			n++;
		end
		@(negedge clk);	// handshake edge has passed
		awvalid_i = 1'b0;
		wvalid_i  = 1'b0;
		n = 0;
		while (!bvalid_o) begin
			if (n == HS_TIMEOUT) begin
				report_timeout("bvalid");
				break;
			end
			@(negedge clk);
			n++;
		end
		repeat (delay) @(negedge clk);	// bready back-pressure
		resp = bresp_o;
		bready_i = 1'b1;
		@(negedge clk);
		bready_i = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int delay;
		n = 0;
		delay = $urandom_range(2, 0);
		@(negedge clk);
		arvalid_i = 1'b1;
		araddr_i  = addr;
		#1;
		while (!arready_o) begin
			if (n == HS_TIMEOUT) begin
				report_timeout("arready");
				break;
			end
			@(negedge clk);
			#1;
			n++;
		end
		@(negedge clk);
		arvalid_i = 1'b0;
		n = 0;
		while (!rvalid_o) begin
			if (n == HS_TIMEOUT) begin
				report_timeout("rvalid");
				break;
			end
			@(negedge clk);
			n++;
		end
		repeat (delay) @(negedge clk);
		data = rdata_o;
		resp = rresp_o;
		rready_i = 1'b1;
		@(negedge clk);
		rready_i = 1'b0;
	endtask

	// one 8N1 frame on uart_rx_i, then two idle bit periods
	task automatic send_serial(input logic [7:0] b, input logic stop_bit);
		@(negedge clk);
		uart_rx_i = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_i = b[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		uart_rx_i = stop_bit;
		repeat (CLKS_PER_BIT) @(negedge clk);
		uart_rx_i = 1'b1;
		repeat (2 * CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic send_rx_byte(input logic [7:0] b);
		send_serial(b, 1'b1);
		if (rx_exp.size() < RX_DEPTH)
			rx_exp.push_back(b);	// dropped when full
	endtask

	task automatic wait_tx_bytes(input int n);
		int k;
		k = 0;
		while (mon_q.size() < n) begin
			if (k == (n + 2) * 12 * CLKS_PER_BIT) begin
				report_timeout("bytes on uart_tx_o");
				break;
			end
			@(negedge clk);
			k++;
		end
	endtask

	task automatic wait_tx_idle();
		int          k;
		logic [31:0] d;
		logic [1:0]  r;
		k = 0;
		axil_read(OFF_STATUS, d, r);
		while (d[2]) begin
			if (k == HS_TIMEOUT) begin
				report_timeout("tx_busy low");
				break;
			end
			axil_read(OFF_STATUS, d, r);
			k++;
		end
	endtask

	task automatic compare_tx();
		check_eq("tx byte count", 32'(tx_exp.size()), 32'(mon_q.size()));
		while (tx_exp.size() > 0 && mon_q.size() > 0)
			check_eq("tx byte", {24'h0, tx_exp.pop_front()}, {24'h0, mon_q.pop_front()});
		tx_exp.delete();
		mon_q.delete();
	endtask

	// decodes uart_tx_o at mid-bit on falling edges
	initial begin : tx_monitor
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (!rst && !uart_tx_o) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					b[i] = uart_tx_o;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				assert (uart_tx_o === 1'b1) else begin
					$display("ERROR: stop bit on uart_tx_o is low in test %s", test_name);
					errors++;
				end
				mon_q.push_back(b);
			end
		end
	end

	task automatic test_reset();
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("reset_state");
		check_eq("uart_tx_o", 32'h1, 32'(uart_tx_o));
		check_eq("uart_rts_o", 32'h0, 32'(uart_rts_o));
		axil_read(OFF_STATUS, d, r);
		check_eq("status resp", 32'(RESP_OKAY), 32'(r));
		check_eq("status", status_word(1'b0, 1'b1, 1'b0), d);
		axil_read(OFF_RX_COUNT, d, r);
		check_eq("rx count resp", 32'(RESP_OKAY), 32'(r));
		check_eq("rx count", 32'h0, d);
		end_test();
	endtask

	task automatic test_tx_path();
		int          n;
		int          accepted;
		logic [31:0] w;
		logic [1:0]  r;
		logic [1:0]  exp_r;
		begin_test("tx_path");
		n = $urandom_range(5, 1);
		for (int i = 0; i < n; i++) begin
			w = $urandom;
			axil_write(OFF_DATA, w, r);
			check_eq("data write resp", 32'(RESP_OKAY), 32'(r));
			tx_exp.push_back(w[7:0]);
		end
		wait_tx_bytes(n);
		compare_tx();
		wait_tx_idle();
		// burst from idle, one byte in flight plus a full fifo
		accepted = 0;
		for (int i = 0; i < TX_DEPTH + 3; i++) begin
			w = $urandom;
			axil_write(OFF_DATA, w, r);
			if (accepted < TX_DEPTH + 1) begin
				exp_r = RESP_OKAY;
				tx_exp.push_back(w[7:0]);
				accepted++;
			end else begin
				exp_r = RESP_SLVERR;
			end
			check_eq("burst write resp", 32'(exp_r), 32'(r));
		end
		wait_tx_bytes(TX_DEPTH + 1);
		compare_tx();
		wait_tx_idle();
		end_test();
	endtask

	task automatic test_rx_path();
		int          n;
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("rx_path");
		n = $urandom_range(4, 1);
		for (int i = 0; i < n; i++)
			send_rx_byte(8'($urandom));
		axil_read(OFF_RX_COUNT, d, r);
		check_eq("rx count", 32'(rx_exp.size()), d);
		while (rx_exp.size() > 0) begin
			axil_read(OFF_DATA, d, r);
			check_eq("data read resp", 32'(RESP_OKAY), 32'(r));
			check_eq("rx byte", {24'h0, rx_exp.pop_front()}, d);
		end
		axil_read(OFF_DATA, d, r);
		check_eq("empty read resp", 32'(RESP_SLVERR), 32'(r));
		check_eq("empty read data", 32'h0, d);
		end_test();
	endtask

	task automatic test_rx_overflow();
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("rx_overflow_rts");
		for (int i = 0; i < RX_DEPTH + 2; i++)
			send_rx_byte(8'($urandom));
		axil_read(OFF_RX_COUNT, d, r);
		check_eq("rx count", 32'(rx_exp.size()), d);
		check_eq("uart_rts_o full", 32'(rx_exp.size() == RX_DEPTH), 32'(uart_rts_o));
		axil_read(OFF_DATA, d, r);
		check_eq("data read resp", 32'(RESP_OKAY), 32'(r));
		check_eq("rx byte", {24'h0, rx_exp.pop_front()}, d);
		check_eq("uart_rts_o after read", 32'h0, 32'(uart_rts_o));
		while (rx_exp.size() > 0) begin
			axil_read(OFF_DATA, d, r);
			check_eq("data read resp", 32'(RESP_OKAY), 32'(r));
			check_eq("rx byte", {24'h0, rx_exp.pop_front()}, d);
		end
		end_test();
	endtask

	task automatic test_cts_hold();
		int          n;
		int          low_cycles;
		logic [31:0] w;
		logic [1:0]  r;
		begin_test("cts_hold");
		@(negedge clk);
		uart_cts_i = 1'b1;
		n = $urandom_range(4, 2);
		for (int i = 0; i < n; i++) begin
			w = $urandom;
			axil_write(OFF_DATA, w, r);
			check_eq("data write resp", 32'(RESP_OKAY), 32'(r));
			tx_exp.push_back(w[7:0]);
		end
		low_cycles = 0;
		for (int k = 0; k < 30 * CLKS_PER_BIT; k++) begin	// three frame times
			@(negedge clk);
			if (!uart_tx_o)
				low_cycles++;
		end
		check_eq("uart_tx_o low cycles", 32'h0, 32'(low_cycles));
		check_eq("bytes sent under cts", 32'h0, 32'(mon_q.size()));
		axil_read(OFF_STATUS, w, r);
		check_eq("status under cts", status_word(1'b0, 1'b1, 1'b0), w);
		@(negedge clk);
		uart_cts_i = 1'b0;
		wait_tx_bytes(n);
		compare_tx();
		wait_tx_idle();
		end_test();
	endtask

	task automatic test_bad_access();
		logic [3:0]  odd_off;
		logic [31:0] d;
		logic [1:0]  r;
		begin_test("bad_access");
		odd_off = 4'($urandom_range(7, 0) * 2 + 1);
		send_rx_byte(8'($urandom));	// one byte waits in the rx fifo
		axil_write(OFF_STATUS, $urandom, r);
		check_eq("status write resp", 32'(RESP_SLVERR), 32'(r));
		axil_write(OFF_RX_COUNT, $urandom, r);
		check_eq("rx count write resp", 32'(RESP_SLVERR), 32'(r));
		axil_write(4'hc, $urandom, r);
		check_eq("unmapped write resp", 32'(RESP_SLVERR), 32'(r));
		axil_write(odd_off, $urandom, r);
		check_eq("odd write resp", 32'(RESP_SLVERR), 32'(r));
		axil_read(4'hc, d, r);
		check_eq("unmapped read resp", 32'(RESP_SLVERR), 32'(r));
		axil_read(odd_off, d, r);
		check_eq("odd read resp", 32'(RESP_SLVERR), 32'(r));
		axil_read(OFF_STATUS, d, r);
		check_eq("status", status_word(1'b0, rx_exp.size() == 0, 1'b0), d);
		axil_read(OFF_RX_COUNT, d, r);
		check_eq("rx count after bad access", 32'(rx_exp.size()), d);
		// bad stop bit, frame is dropped
		send_serial(8'($urandom), 1'b0);
		axil_read(OFF_RX_COUNT, d, r);
		check_eq("rx count after bad stop", 32'(rx_exp.size()), d);
		check_eq("bytes on uart_tx_o", 32'h0, 32'(mon_q.size()));
		send_rx_byte(8'($urandom));
		while (rx_exp.size() > 0) begin
			axil_read(OFF_DATA, d, r);
			check_eq("data read resp", 32'(RESP_OKAY), 32'(r));
			check_eq("rx byte after bad access", {24'h0, rx_exp.pop_front()}, d);
		end
		end_test();
	endtask

	initial begin
		void'($urandom(23830));
		rst        = 1'b1;
		awvalid_i  = 1'b0;
		awaddr_i   = '0;
		wvalid_i   = 1'b0;
		wdata_i    = '0;
		wstrb_i    = '0;
		bready_i   = 1'b0;
		arvalid_i  = 1'b0;
		araddr_i   = '0;
		rready_i   = 1'b0;
		uart_rx_i  = 1'b1;	// idle line
		uart_cts_i = 1'b0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name    = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_reset();
		test_tx_path();
		test_rx_path();
		test_rx_overflow();
		test_cts_hold();
		test_bad_access();

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule : tb_uart_axil

/* uart_axil.sv */
module uart_axil #(
	parameter int CLK_FREQ      = 50_000_000,
	parameter int UART_BPS      = 115_200,
	parameter int TX_DEPTH_LOG2 = 4,
	parameter int RX_DEPTH_LOG2 = 4,
	parameter int ADDR_WIDTH    = 4
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   awvalid_i,
	input  logic [ADDR_WIDTH-1:0]                  awaddr_i,
	input  logic                                   wvalid_i,
	input  logic [axil_pkg::AXIL_DATA_W-1:0]       wdata_i,
	input  logic [axil_pkg::AXIL_DATA_W/8-1:0]     wstrb_i,
	input  logic                                   bready_i,
	input  logic                                   arvalid_i,
	input  logic [ADDR_WIDTH-1:0]                  araddr_i,
	input  logic                                   rready_i,
	output logic                                   awready_o,
	output logic                                   wready_o,
	output logic                                   bvalid_o,
	output logic [$bits(axil_pkg::resp_e)-1:0]     bresp_o,
	output logic                                   arready_o,
	output logic                                   rvalid_o,
	output logic [axil_pkg::AXIL_DATA_W-1:0]       rdata_o,
	output logic [$bits(axil_pkg::resp_e)-1:0]     rresp_o,
	input  logic                                   uart_rx_i,
	input  logic                                   uart_cts_i,	// high holds tx
	output logic                                   uart_tx_o,
	output logic                                   uart_rts_o	// high when rx fifo full
);

	localparam int CLKS_PER_BIT = CLK_FREQ / UART_BPS;

	logic       tx_send;
	logic       tx_busy;
	logic [7:0] tx_byte;
	logic       rx_valid;
	logic [7:0] rx_byte;

	fifo_if #(.DEPTH_LOG2(TX_DEPTH_LOG2)) tx_fifo_bus ();
	fifo_if #(.DEPTH_LOG2(RX_DEPTH_LOG2)) rx_fifo_bus ();

	uart_ctrl #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) uart_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.awvalid_i  (awvalid_i),
		.awaddr_i   (awaddr_i),
		.wvalid_i   (wvalid_i),
		.wdata_i    (wdata_i),
		.wstrb_i    (wstrb_i),
		.bready_i   (bready_i),
		.arvalid_i  (arvalid_i),
		.araddr_i   (araddr_i),
		.rready_i   (rready_i),
		.awready_o  (awready_o),
		.wready_o   (wready_o),
		.bvalid_o   (bvalid_o),
		.bresp_o    (bresp_o),
		.arready_o  (arready_o),
		.rvalid_o   (rvalid_o),
		.rdata_o    (rdata_o),
		.rresp_o    (rresp_o),
		.tx_fifo_o  (tx_fifo_bus.user),
		.rx_fifo_o  (rx_fifo_bus.user),
		.tx_busy_i  (tx_busy),
		.tx_send_o  (tx_send),
		.tx_byte_o  (tx_byte),
		.rx_valid_i (rx_valid),
		.rx_byte_i  (rx_byte),
		.cts_i      (uart_cts_i),
		.rts_o      (uart_rts_o)
	);

	sync_fifo tx_fifo_inst (
		.clk    (clk),
		.rst    (rst),
		.fifo_i (tx_fifo_bus.store)
	);

	sync_fifo rx_fifo_inst (
		.clk    (clk),
		.rst    (rst),
		.fifo_i (rx_fifo_bus.store)
	);

	uart_tx_phy #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_tx_phy_inst (
		.clk    (clk),
		.rst    (rst),
		.send_i (tx_send),
		.byte_i (tx_byte),
		.busy_o (tx_busy),
		.tx_o   (uart_tx_o)
	);

	uart_rx_phy #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_rx_phy_inst (
		.clk     (clk),
		.rst     (rst),
		.rx_i    (uart_rx_i),
		.valid_o (rx_valid),
		.byte_o  (rx_byte)
	);

endmodule : uart_axil

/* uart_ctrl.sv */
module uart_ctrl #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            awvalid_i,
	input  logic [ADDR_WIDTH-1:0]           awaddr_i,
	input  logic                            wvalid_i,
	input  logic [axil_pkg::AXIL_DATA_W-1:0] wdata_i,
	input  logic [3:0]                      wstrb_i,
	input  logic                            bready_i,
	input  logic                            arvalid_i,
	input  logic [ADDR_WIDTH-1:0]           araddr_i,
	input  logic                            rready_i,
	output logic                            awready_o,
	output logic                            wready_o,
	output logic                            bvalid_o,
	output logic [1:0]                      bresp_o,
	output logic                            arready_o,
	output logic                            rvalid_o,
	output logic [axil_pkg::AXIL_DATA_W-1:0] rdata_o,
	output logic [1:0]                      rresp_o,
	fifo_if.user                            tx_fifo_o,
	fifo_if.user                            rx_fifo_o,
	input  logic                            tx_busy_i,
	output logic                            tx_send_o,
	output logic [7:0]                      tx_byte_o,
	input  logic                            rx_valid_i,
	input  logic [7:0]                      rx_byte_i,
	input  logic                            cts_i,
	output logic                            rts_o
);

	uart_pkg::bus_state_e             state;
	axil_pkg::resp_e                  wr_resp;
	axil_pkg::resp_e                  rd_resp;
	axil_pkg::resp_e                  bresp_q;
	axil_pkg::resp_e                  rresp_q;
	logic [axil_pkg::AXIL_DATA_W-1:0] rd_data;
	logic [axil_pkg::AXIL_DATA_W-1:0] rdata_q;
	logic                             wr_accept;
	logic                             rd_accept;
	logic                             tx_send_q;

	// a write wins over a read in the same cycle
	assign wr_accept = (state == uart_pkg::BUS_IDLE) && awvalid_i && wvalid_i;
	assign rd_accept = (state == uart_pkg::BUS_IDLE) && arvalid_i && !wr_accept;

	assign awready_o = wr_accept;
	assign wready_o  = wr_accept;
	assign arready_o = rd_accept;

	always_comb begin
		wr_resp           = axil_pkg::SLVERR;
		tx_fifo_o.push    = 1'b0;
		tx_fifo_o.push_data = wdata_i[7:0];
		case (awaddr_i)
			uart_pkg::REG_DATA: begin
				if (!tx_fifo_o.full) begin
					wr_resp        = axil_pkg::OKAY;
					tx_fifo_o.push = wr_accept && wstrb_i[0];
				end
			end
			default: wr_resp = axil_pkg::SLVERR;	// read-only or unmapped
		endcase
	end

	always_comb begin
		rd_resp       = axil_pkg::OKAY;
		rd_data       = '0;
		rx_fifo_o.pop = 1'b0;
		case (araddr_i)
			uart_pkg::REG_DATA: begin
				if (rx_fifo_o.empty) begin
					rd_resp = axil_pkg::SLVERR;
				end else begin
					rd_data[7:0]  = rx_fifo_o.pop_data;
					rx_fifo_o.pop = rd_accept;
				end
			end
			uart_pkg::REG_RX_COUNT: rd_data[$bits(rx_fifo_o.count)-1:0] = rx_fifo_o.count;
			uart_pkg::REG_STATUS: begin
				rd_data[uart_pkg::STAT_TX_FULL]  = tx_fifo_o.full;
				rd_data[uart_pkg::STAT_RX_EMPTY] = rx_fifo_o.empty;
				rd_data[uart_pkg::STAT_TX_BUSY]  = tx_busy_i;
			end
			default: rd_resp = axil_pkg::SLVERR;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state   <= uart_pkg::BUS_IDLE;
			bresp_q <= axil_pkg::OKAY;
			rresp_q <= axil_pkg::OKAY;
		end else begin
			case (state)
				uart_pkg::BUS_IDLE: begin
					if (wr_accept) begin
						state   <= uart_pkg::WRITE_RESP;
						bresp_q <= wr_resp;
					end else if (rd_accept) begin
						state   <= uart_pkg::READ_RESP;
						rresp_q <= rd_resp;
					end
				end
				uart_pkg::WRITE_RESP: if (bready_i) state <= uart_pkg::BUS_IDLE;
				uart_pkg::READ_RESP:  if (rready_i) state <= uart_pkg::BUS_IDLE;
				default:              state <= uart_pkg::BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept)
			rdata_q <= rd_data;
	end

	assign bvalid_o = (state == uart_pkg::WRITE_RESP);
	assign rvalid_o = (state == uart_pkg::READ_RESP);
	assign bresp_o  = bresp_q;
	assign rresp_o  = rresp_q;
	assign rdata_o  = rdata_q;

	// launch the next byte once the serializer is free
	assign tx_send_o     = !tx_fifo_o.empty && !tx_busy_i && !cts_i && !tx_send_q;
	assign tx_fifo_o.pop = tx_send_o;
	assign tx_byte_o     = tx_fifo_o.pop_data;

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			tx_send_q <= 1'b0;
		else
			tx_send_q <= tx_send_o;
	end

	// received byte is lost when the fifo is full
	assign rx_fifo_o.push      = rx_valid_i && !rx_fifo_o.full;
	assign rx_fifo_o.push_data = rx_byte_i;
	assign rts_o               = rx_fifo_o.full;

	bresp_stable: assert property (@(posedge clk) disable iff (rst)
		bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

	rdata_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

	// serializer takes every launched byte
	busy_after_send: assert property (@(posedge clk) disable iff (rst)
		tx_send_o |=> tx_busy_i);

endmodule : uart_ctrl

/* uart_pkg.sv */
package uart_pkg;

	// register offsets, byte addressed
	typedef enum logic [3:0] {
		REG_DATA     = 4'h0,
		REG_RX_COUNT = 4'h4,
		REG_STATUS   = 4'h8
	} reg_off_e;

	typedef enum logic [1:0] {
		BUS_IDLE,
		WRITE_RESP,
		READ_RESP
	} bus_state_e;

	// serial frame phases, shared by tx and rx
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	localparam int STAT_TX_FULL  = 0;
	localparam int STAT_RX_EMPTY = 1;
	localparam int STAT_TX_BUSY  = 2;

endpackage : uart_pkg

/* uart_rx_phy.sv */
module uart_rx_phy #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_i,
	output logic       valid_o,
	output logic [7:0] byte_o
);

	localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;
	localparam int CNT_W = $clog2(2 * CLKS_PER_BIT);

	uart_pkg::tx_state_e state;
	logic                rx_meta;
	logic                rx_sync;
	logic [CNT_W-1:0]    cnt;
	logic [2:0]          bit_idx;
	logic [7:0]          shreg;
	logic                stop_ok;
	logic                mid_start;
	logic                bit_end;
	logic                stop_end;

	assign mid_start = (cnt == CNT_W'(HALF - 1));
	assign bit_end   = (cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign stop_end  = (cnt == CNT_W'(CLKS_PER_BIT + HALF - 1));

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_DATA && bit_end)
			shreg <= {rx_sync, shreg[7:1]};	// lsb first
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state   <= uart_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			stop_ok <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= 1'b0;
			cnt     <= cnt + 1'b1;
			case (state)
				uart_pkg::TX_IDLE: begin
					cnt <= '0;
					if (!rx_sync)
						state <= uart_pkg::TX_START;
				end
				uart_pkg::TX_START: begin
					if (mid_start) begin
						cnt     <= '0;
						bit_idx <= '0;
						// glitch shorter than half a bit
						state   <= rx_sync ? uart_pkg::TX_IDLE : uart_pkg::TX_DATA;
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= uart_pkg::TX_STOP;
					end
				end
				default: begin
					if (bit_end)
						stop_ok <= rx_sync;	// middle of stop bit
					if (stop_end) begin
						valid_o <= stop_ok;
						state   <= uart_pkg::TX_IDLE;
					end
				end
			endcase
		end
	end

	assign byte_o = shreg;

endmodule : uart_rx_phy

/* uart_tx_phy.sv */
module uart_tx_phy #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       send_i,
	input  logic [7:0] byte_i,
	output logic       busy_o,
	output logic       tx_o
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	uart_pkg::tx_state_e state;
	logic [CNT_W-1:0]    cnt;
	logic [2:0]          bit_idx;
	logic [7:0]          shreg;
	logic                bit_end;

	assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));

	// shift register, lsb goes out first
	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_IDLE && send_i)
			shreg <= byte_i;
		else if (bit_end && state inside {uart_pkg::TX_START, uart_pkg::TX_DATA})
			shreg <= shreg >> 1;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state   <= uart_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			tx_o    <= 1'b1;
		end else begin
			cnt <= bit_end ? '0 : cnt + 1'b1;
			case (state)
				uart_pkg::TX_IDLE: begin
					cnt  <= '0;
					tx_o <= 1'b1;
					if (send_i) begin
						state <= uart_pkg::TX_START;
						tx_o  <= 1'b0;	// start bit
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						state   <= uart_pkg::TX_DATA;
						bit_idx <= '0;
						tx_o    <= shreg[0];
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::TX_STOP;
							tx_o  <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx_o    <= shreg[0];
						end
					end
				end
				default: begin
					if (bit_end)
						state <= uart_pkg::TX_IDLE;	// stop bit done
				end
			endcase
		end
	end

	assign busy_o = (state != uart_pkg::TX_IDLE);

endmodule : uart_tx_phy

/* verilog.f */
axil_pkg.sv
uart_pkg.sv
fifo_if.sv
sync_fifo.sv
uart_tx_phy.sv
uart_rx_phy.sv
uart_ctrl.sv
uart_axil.sv
tb_uart_axil.sv
